// File: hdl/pe_noc_defines.svh
`ifndef PE_NOC_DEFINES_SVH
`define PE_NOC_DEFINES_SVH

// Address and data bus widths
`define NOC_ADDR_W 32
`define NOC_DATA_W 32

// Requester ID as seen upstream
`define NOC_REQ_ID_W 4

// Narrow sequence tag sent downstream, wraps every four transactions
`define NOC_TAG_W 2

// Cluster count is fixed for this network
`define NOC_NUM_CL 2

// Clusters plus the L2 data and L2 program ports
`define NOC_NUM_TGT 4

`endif

// File: hdl/pe_noc_pkg.sv
package pe_noc_pkg;

  `include "pe_noc_defines.svh"

  typedef logic [`NOC_ADDR_W-1:0]   addr_t;
  typedef logic [`NOC_DATA_W-1:0]   data_t;
  typedef logic [`NOC_REQ_ID_W-1:0] req_id_t;
  typedef logic [`NOC_TAG_W-1:0]    tag_t;

  // Encoding doubles as the downstream port index
  typedef enum logic [2:0] {
    TGT_CL0  = 3'd0,
    TGT_CL1  = 3'd1,
    TGT_L2D  = 3'd2,
    TGT_L2I  = 3'd3,
    TGT_NONE = 3'd4
  } noc_target_e;

  // Port controller FSM
  typedef enum logic [2:0] {
    ST_IDLE   = 3'd0,
    ST_DECODE = 3'd1,
    ST_REQ    = 3'd2,
    ST_REL    = 3'd3,
    ST_ACK    = 3'd4
  } noc_state_e;

endpackage

// File: hdl/pe_noc_addr_decoder.sv
`timescale 1ns/1ps

`include "pe_noc_defines.svh"

module pe_noc_addr_decoder (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic                                     cap_en_i,
  input  pe_noc_pkg::addr_t                        addr_i,

  // Address map
  input  pe_noc_pkg::addr_t [`NOC_NUM_CL-1:0]      cl_start_addr_i,
  input  pe_noc_pkg::addr_t [`NOC_NUM_CL-1:0]      cl_end_addr_i,
  input  pe_noc_pkg::addr_t                        l2d_start_addr_i,
  input  pe_noc_pkg::addr_t                        l2d_end_addr_i,
  input  pe_noc_pkg::addr_t                        l2i_start_addr_i,
  input  pe_noc_pkg::addr_t                        l2i_end_addr_i,

  output pe_noc_pkg::noc_target_e                  target_o
);

  import pe_noc_pkg::*;

  noc_target_e target_d;
  noc_target_e target_q;

  // Both range bounds are inclusive
  function automatic logic in_range(addr_t addr, addr_t lo, addr_t hi);
    return (addr >= lo) && (addr <= hi);
  endfunction

  // Rules are checked from lowest to highest priority so the last hit wins,
  // which leaves cluster 0 as the first match when ranges overlap
  always_comb begin
    target_d = TGT_NONE;
    if (in_range(addr_i, l2i_start_addr_i, l2i_end_addr_i)) begin
      target_d = TGT_L2I;
    end
    if (in_range(addr_i, l2d_start_addr_i, l2d_end_addr_i)) begin
      target_d = TGT_L2D;
    end
    for (int i = `NOC_NUM_CL - 1; i >= 0; i--) begin
      if (in_range(addr_i, cl_start_addr_i[i], cl_end_addr_i[i])) begin
        target_d = noc_target_e'(3'(i));
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      target_q <= TGT_NONE;
    end else if (cap_en_i) begin
      target_q <= target_d;
    end
  end

  assign target_o = target_q;

endmodule

// File: hdl/pe_noc_txn_tagger.sv
`timescale 1ns/1ps

`include "pe_noc_defines.svh"

module pe_noc_txn_tagger (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    cap_en_i,
  input  pe_noc_pkg::req_id_t     id_i,
  input  pe_noc_pkg::noc_target_e target_i,
  input  logic                    txn_done_i,
  output pe_noc_pkg::tag_t        tag_o,
  output pe_noc_pkg::req_id_t     saved_id_o
);

  import pe_noc_pkg::*;

  tag_t                            seq_cnt_q [`NOC_NUM_TGT];
  req_id_t                         saved_id_q;
  logic [$clog2(`NOC_NUM_TGT)-1:0] port_idx;

  // Only meaningful when a real target was decoded
  assign port_idx = target_i[$clog2(`NOC_NUM_TGT)-1:0];

  // One sequence counter per downstream port
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int k = 0; k < `NOC_NUM_TGT; k++) begin
        seq_cnt_q[k] <= '0;
      end
    end else if (txn_done_i && (target_i != TGT_NONE)) begin
      // Natural wrap at the tag width
      seq_cnt_q[port_idx] <= seq_cnt_q[port_idx] + 1'b1;
    end
  end

  // Original ID is held for the upstream response
  always_ff @(posedge clk_i) begin
    if (cap_en_i) begin
      saved_id_q <= id_i;
    end
  end

  assign tag_o      = (target_i == TGT_NONE) ? '0 : seq_cnt_q[port_idx];
  assign saved_id_o = saved_id_q;

endmodule

// File: hdl/pe_noc_port_ctrl.sv
`timescale 1ns/1ps

`include "pe_noc_defines.svh"

module pe_noc_port_ctrl (
  input  logic                                 clk_i,
  input  logic                                 rst_i,

  // Upstream requester
  input  logic                                 req_i,
  input  logic                                 write_i,
  input  pe_noc_pkg::addr_t                    addr_i,
  input  pe_noc_pkg::data_t                    wdata_i,
  output logic                                 ack_o,
  output logic                                 err_o,
  output pe_noc_pkg::data_t                    rdata_o,

  // Decoder result and internal pulses
  input  pe_noc_pkg::noc_target_e              target_i,
  output logic                                 cap_en_o,
  output logic                                 txn_done_o,

  // Downstream ports
  output logic [`NOC_NUM_TGT-1:0]              tgt_req_o,
  output logic                                 tgt_write_o,
  output pe_noc_pkg::addr_t                    tgt_addr_o,
  output pe_noc_pkg::data_t                    tgt_wdata_o,
  input  logic [`NOC_NUM_TGT-1:0]              tgt_ack_i,
  input  pe_noc_pkg::data_t [`NOC_NUM_TGT-1:0] tgt_rdata_i
);

  import pe_noc_pkg::*;

  noc_state_e                      state_q;
  logic                            ack_q;
  logic                            err_q;
  logic [`NOC_NUM_TGT-1:0]         tgt_req_q;
  logic [$clog2(`NOC_NUM_TGT)-1:0] port_idx;
  logic                            sel_ack;

  // Captured request and response payload
  logic                            write_q;
  addr_t                           addr_q;
  data_t                           wdata_q;
  data_t                           rdata_q;

  assign port_idx = target_i[$clog2(`NOC_NUM_TGT)-1:0];
  assign sel_ack  = tgt_ack_i[port_idx];

  // Both pulses last one cycle since the state moves on at the next edge
  assign cap_en_o   = (state_q == ST_IDLE) && req_i;
  assign txn_done_o = (state_q == ST_ACK) && !req_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= ST_IDLE;
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
      tgt_req_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_i) begin
            state_q <= ST_DECODE;
          end
        end
        ST_DECODE: begin
          if (target_i == TGT_NONE) begin
            // Unmapped address, answer directly without a downstream request
            err_q   <= 1'b1;
            ack_q   <= 1'b1;
            state_q <= ST_ACK;
          end else begin
            err_q               <= 1'b0;
            tgt_req_q[port_idx] <= 1'b1;
            state_q             <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (sel_ack) begin
            tgt_req_q <= '0;
            state_q   <= ST_REL;
          end
        end
        ST_REL: begin
          // Target must release its ack before upstream sees completion
          if (!sel_ack) begin
            ack_q   <= 1'b1;
            state_q <= ST_ACK;
          end
        end
        ST_ACK: begin
          if (!req_i) begin
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (cap_en_o) begin
      write_q <= write_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  // Read data only for successful reads, zero otherwise
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_DECODE) && (target_i == TGT_NONE)) begin
      rdata_q <= '0;
    end else if ((state_q == ST_REQ) && sel_ack) begin
      rdata_q <= write_q ? '0 : tgt_rdata_i[port_idx];
    end
  end

  assign ack_o       = ack_q;
  assign err_o       = err_q;
  assign rdata_o     = rdata_q;
  assign tgt_req_o   = tgt_req_q;
  assign tgt_write_o = write_q;
  assign tgt_addr_o  = addr_q;
  assign tgt_wdata_o = wdata_q;

endmodule

// File: hdl/pe_noc_top.sv
`timescale 1ns/1ps

`include "pe_noc_defines.svh"

module pe_noc_top (
  input  logic                                 clk_i,
  input  logic                                 rst_i,

  // Upstream requester
  input  logic                                 req_i,
  input  logic                                 write_i,
  input  pe_noc_pkg::addr_t                    addr_i,
  input  pe_noc_pkg::data_t                    wdata_i,
  input  pe_noc_pkg::req_id_t                  id_i,
  output logic                                 ack_o,
  output logic                                 err_o,
  output pe_noc_pkg::data_t                    rdata_o,
  output pe_noc_pkg::req_id_t                  rid_o,

  // Address map
  input  pe_noc_pkg::addr_t [`NOC_NUM_CL-1:0]  cl_start_addr_i,
  input  pe_noc_pkg::addr_t [`NOC_NUM_CL-1:0]  cl_end_addr_i,
  input  pe_noc_pkg::addr_t                    l2d_start_addr_i,
  input  pe_noc_pkg::addr_t                    l2d_end_addr_i,
  input  pe_noc_pkg::addr_t                    l2i_start_addr_i,
  input  pe_noc_pkg::addr_t                    l2i_end_addr_i,

  // Downstream ports, cluster 0, cluster 1, L2 data, L2 program
  output logic [`NOC_NUM_TGT-1:0]              tgt_req_o,
  output logic                                 tgt_write_o,
  output pe_noc_pkg::addr_t                    tgt_addr_o,
  output pe_noc_pkg::data_t                    tgt_wdata_o,
  output pe_noc_pkg::tag_t                     tgt_tag_o,
  input  logic [`NOC_NUM_TGT-1:0]              tgt_ack_i,
  input  pe_noc_pkg::data_t [`NOC_NUM_TGT-1:0] tgt_rdata_i
);

  import pe_noc_pkg::*;

  logic        cap_en;
  logic        txn_done;
  noc_target_e target;

  pe_noc_addr_decoder i_addr_decoder (
    .clk_i,
    .rst_i,
    .cap_en_i         (cap_en),
    .addr_i,
    .cl_start_addr_i,
    .cl_end_addr_i,
    .l2d_start_addr_i,
    .l2d_end_addr_i,
    .l2i_start_addr_i,
    .l2i_end_addr_i,
    .target_o         (target)
  );

  // Tagger works beside the decoder on the same captured request
  pe_noc_txn_tagger i_txn_tagger (
    .clk_i,
    .rst_i,
    .cap_en_i   (cap_en),
    .id_i,
    .target_i   (target),
    .txn_done_i (txn_done),
    .tag_o      (tgt_tag_o),
    .saved_id_o (rid_o)
  );

  pe_noc_port_ctrl i_port_ctrl (
    .clk_i,
    .rst_i,
    .req_i,
    .write_i,
    .addr_i,
    .wdata_i,
    .ack_o,
    .err_o,
    .rdata_o,
    .target_i    (target),
    .cap_en_o    (cap_en),
    .txn_done_o  (txn_done),
    .tgt_req_o,
    .tgt_write_o,
    .tgt_addr_o,
    .tgt_wdata_o,
    .tgt_ack_i,
    .tgt_rdata_i
  );

endmodule

// File: verification/pe_noc_properties.sv
`timescale 1ns/1ps

`include "pe_noc_defines.svh"

module pe_noc_properties (
  input logic                    clk_i,
  input logic                    rst_i,
  input logic                    req_i,
  input logic                    ack_i,
  input logic [`NOC_NUM_TGT-1:0] tgt_req_i
);

  // Only one downstream port per transaction
  onehot_tgt_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(tgt_req_i))
    else $error("More than one tgt_req_o bit is high");

  // Upstream ack answers a pending request
  ack_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ack_i) |-> req_i)
    else $error("ack_o rose without req_i");

  no_tgt_req_in_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_i |-> (tgt_req_i == '0))
    else $error("tgt_req_o is high while ack_o is high");

  // Ack follows the release of req one cycle later
  ack_release: assert property (@(posedge clk_i) disable iff (rst_i)
    (ack_i && !req_i) |=> !ack_i)
    else $error("ack_o stayed high after req_i fell");

endmodule

bind pe_noc_top pe_noc_properties pe_noc_properties_i (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .req_i     (req_i),
  .ack_i     (ack_o),
  .tgt_req_i (tgt_req_o)
);

// File: verification/pe_noc_tb.sv
`timescale 1ns/1ps

`include "pe_noc_defines.svh"

// Downstream target model, answers one port after a programmable delay
module target_responder (
  input  logic              clk_i,
  input  logic [1:0]        port_idx_i,
  input  logic [1:0]        delay_i,
  input  logic              req_i,
  input  logic              write_i,
  input  pe_noc_pkg::addr_t addr_i,
  input  pe_noc_pkg::data_t wdata_i,
  input  pe_noc_pkg::tag_t  tag_i,
  output logic              ack_o,
  output pe_noc_pkg::data_t rdata_o,
  output logic              last_write_o,
  output pe_noc_pkg::addr_t last_addr_o,
  output pe_noc_pkg::data_t last_wdata_o,
  output pe_noc_pkg::tag_t  last_tag_o,
  output int                hits_o
);

  initial begin
    ack_o        = 1'b0;
    rdata_o      = '0;
    last_write_o = 1'b0;
    last_addr_o  = '0;
    last_wdata_o = '0;
    last_tag_o   = '0;
    hits_o       = 0;
    forever begin
      @(posedge clk_i);
      #1;
      if (req_i === 1'b1) begin
        last_write_o = write_i;
        last_addr_o  = addr_i;
        last_wdata_o = wdata_i;
        last_tag_o   = tag_i;
        hits_o       = hits_o + 1;
        repeat (delay_i) begin
          @(posedge clk_i);
          #1;
        end
        // Port index in the top bits, address below
        rdata_o = {port_idx_i, addr_i[29:0]};
        ack_o   = 1'b1;
        do begin
          @(posedge clk_i);
          #1;
        end while (req_i !== 1'b0);
        ack_o   = 1'b0;
        rdata_o = '0;
      end
    end
  end

endmodule

module pe_noc_tb;

  import pe_noc_pkg::*;

  localparam int NUM_TESTS      = 14;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 20 + RESET_CYCLES;

  logic                            clk;
  logic                            rst;
  logic                            req;
  logic                            write;
  addr_t                           addr;
  data_t                           wdata;
  req_id_t                         id;
  logic                            ack;
  logic                            err;
  data_t                           rdata;
  req_id_t                         rid;
  addr_t [`NOC_NUM_CL-1:0]         cl_start;
  addr_t [`NOC_NUM_CL-1:0]         cl_end;
  logic [`NOC_NUM_TGT-1:0]         tgt_req;
  logic                            tgt_write;
  addr_t                           tgt_addr;
  data_t                           tgt_wdata;
  tag_t                            tgt_tag;
  logic [`NOC_NUM_TGT-1:0]         tgt_ack;
  data_t [`NOC_NUM_TGT-1:0]        tgt_rdata;
  logic [1:0]                      resp_delay;

  // What each target model last saw
  logic                            seen_write [`NOC_NUM_TGT];
  addr_t                           seen_addr  [`NOC_NUM_TGT];
  data_t                           seen_wdata [`NOC_NUM_TGT];
  tag_t                            seen_tag   [`NOC_NUM_TGT];
  int                              seen_hits  [`NOC_NUM_TGT];

  // Stimulus table with expected routing
  logic                            tbl_write [NUM_TESTS];
  addr_t                           tbl_addr  [NUM_TESTS];
  data_t                           tbl_wdata [NUM_TESTS];
  req_id_t                         tbl_id    [NUM_TESTS];
  noc_target_e                     tbl_tgt   [NUM_TESTS];
  logic                            tbl_err   [NUM_TESTS];

  tag_t                            tag_count [`NOC_NUM_TGT];
  logic [31:0]                     rng;
  int                              cycle_cnt = 0;
  int                              errors;
  int                              failed;
  int                              err_before;

  assign cl_start[0] = 32'h0000_1000;
  assign cl_end[0]   = 32'h0000_1FFF;
  assign cl_start[1] = 32'h0000_2000;
  assign cl_end[1]   = 32'h0000_2FFF;

  pe_noc_top pe_noc_top_i (
    .clk_i            (clk),
    .rst_i            (rst),
    .req_i            (req),
    .write_i          (write),
    .addr_i           (addr),
    .wdata_i          (wdata),
    .id_i             (id),
    .ack_o            (ack),
    .err_o            (err),
    .rdata_o          (rdata),
    .rid_o            (rid),
    .cl_start_addr_i  (cl_start),
    .cl_end_addr_i    (cl_end),
    .l2d_start_addr_i (32'h0000_8000),
    .l2d_end_addr_i   (32'h0000_BFFF),
    .l2i_start_addr_i (32'h0000_C000),
    .l2i_end_addr_i   (32'h0000_CFFF),
    .tgt_req_o        (tgt_req),
    .tgt_write_o      (tgt_write),
    .tgt_addr_o       (tgt_addr),
    .tgt_wdata_o      (tgt_wdata),
    .tgt_tag_o        (tgt_tag),
    .tgt_ack_i        (tgt_ack),
    .tgt_rdata_i      (tgt_rdata)
  );

  for (genvar k = 0; k < `NOC_NUM_TGT; k++) begin : g_target
    target_responder target_responder_i (
      .clk_i        (clk),
      .port_idx_i   (2'(k)),
      .delay_i      (resp_delay),
      .req_i        (tgt_req[k]),
      .write_i      (tgt_write),
      .addr_i       (tgt_addr),
      .wdata_i      (tgt_wdata),
      .tag_i        (tgt_tag),
      .ack_o        (tgt_ack[k]),
      .rdata_o      (tgt_rdata[k]),
      .last_write_o (seen_write[k]),
      .last_addr_o  (seen_addr[k]),
      .last_wdata_o (seen_wdata[k]),
      .last_tag_o   (seen_tag[k]),
      .hits_o       (seen_hits[k])
    );
  end

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a handshake never completed", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Reads return the model pattern, writes and errors return zero
  function automatic data_t expected_rdata(int idx);
    logic [2:0] port;
    port = tbl_tgt[idx];
    if (tbl_err[idx] || tbl_write[idx]) begin
      return '0;
    end
    return {port[1:0], tbl_addr[idx][29:0]};
  endfunction

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_target(string name, noc_target_e got, noc_target_e exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_tag(string name, tag_t got, tag_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_id(string name, req_id_t got, req_id_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic add_entry(int idx, logic w, addr_t a, data_t d, req_id_t i,
                           noc_target_e t, logic e);
    tbl_write[idx] = w;
    tbl_addr[idx]  = a;
    tbl_wdata[idx] = d;
    tbl_id[idx]    = i;
    tbl_tgt[idx]   = t;
    tbl_err[idx]   = e;
  endtask

  task automatic load_table();
    // Range boundaries, gaps between ranges and a tag wrap on cluster 0
    add_entry(0,  1'b1, 32'h0000_1000, 32'hA5A5_0001, 4'h1, TGT_CL0,  1'b0);
    add_entry(1,  1'b0, 32'h0000_1FFF, 32'h0000_0000, 4'h2, TGT_CL0,  1'b0);
    add_entry(2,  1'b1, 32'h0000_2000, 32'h1234_5678, 4'h3, TGT_CL1,  1'b0);
    add_entry(3,  1'b0, 32'h0000_0FFF, 32'h0000_0000, 4'h4, TGT_NONE, 1'b1);
    add_entry(4,  1'b0, 32'h0000_8000, 32'h0000_0000, 4'h5, TGT_L2D,  1'b0);
    add_entry(5,  1'b1, 32'h0000_BFFF, 32'hDEAD_BEEF, 4'h6, TGT_L2D,  1'b0);
    add_entry(6,  1'b0, 32'h0000_C000, 32'h0000_0000, 4'h7, TGT_L2I,  1'b0);
    add_entry(7,  1'b0, 32'h0000_CFFF, 32'h0000_0000, 4'h8, TGT_L2I,  1'b0);
    add_entry(8,  1'b1, 32'h0000_D000, 32'h0BAD_0BAD, 4'h9, TGT_NONE, 1'b1);
    add_entry(9,  1'b0, 32'h0000_1800, 32'h0000_0000, 4'hA, TGT_CL0,  1'b0);
    add_entry(10, 1'b1, 32'h0000_2FFF, 32'hCAFE_F00D, 4'hB, TGT_CL1,  1'b0);
    add_entry(11, 1'b0, 32'h0000_1004, 32'h0000_0000, 4'hC, TGT_CL0,  1'b0);
    add_entry(12, 1'b1, 32'h0000_1ABC, 32'h5A5A_A5A5, 4'hD, TGT_CL0,  1'b0);
    add_entry(13, 1'b0, 32'h0000_3000, 32'h0000_0000, 4'hE, TGT_NONE, 1'b1);
  endtask

  // One four-phase transaction with all checks on its response
  task automatic run_entry(int idx);
    int                      hits_before [`NOC_NUM_TGT];
    int                      req_cycle;
    int                      latency;
    int                      hit_ports;
    int                      port;
    logic                    any_req;
    logic [`NOC_NUM_TGT-1:0] prev_tgt_ack;
    logic [`NOC_NUM_TGT-1:0] cur_tgt_ack;
    noc_target_e             hit_tgt;
    for (int k = 0; k < `NOC_NUM_TGT; k++) begin
      hits_before[k] = seen_hits[k];
    end
    rng          = xorshift32(rng);
    resp_delay   = rng[1:0];
    any_req      = 1'b0;
    prev_tgt_ack = '0;
    cur_tgt_ack  = '0;
    @(posedge clk);
    #1;
    write     = tbl_write[idx];
    addr      = tbl_addr[idx];
    wdata     = tbl_wdata[idx];
    id        = tbl_id[idx];
    req       = 1'b1;
    req_cycle = cycle_cnt;
    do begin
      prev_tgt_ack = cur_tgt_ack;
      @(negedge clk);
      cur_tgt_ack = tgt_ack;
      any_req     = any_req | (|tgt_req);
    end while (ack !== 1'b1);
    // The cycle in which req rises counts as the first
    latency = cycle_cnt - req_cycle + 1;
    // The target ack must already be low in the cycle before ack_o rises
    if ((prev_tgt_ack | cur_tgt_ack) != '0) begin
      $display("At %0t ack_o rose before the target released its ack", $time);
      errors++;
    end
    hit_tgt   = TGT_NONE;
    hit_ports = 0;
    for (int k = 0; k < `NOC_NUM_TGT; k++) begin
      if (seen_hits[k] != hits_before[k]) begin
        hit_tgt = noc_target_e'(3'(k));
        hit_ports++;
      end
    end
    if (hit_ports > 1) begin
      $display("At %0t the request reached %0d target ports", $time, hit_ports);
      errors++;
    end
    check_target("target", hit_tgt, tbl_tgt[idx]);
    check_flag("err_o", err, tbl_err[idx]);
    check_data("rdata_o", rdata, expected_rdata(idx));
    check_id("rid_o", rid, tbl_id[idx]);
    if (tbl_err[idx]) begin
      if (any_req) begin
        $display("At %0t a downstream request was raised for an unmapped address", $time);
        errors++;
      end
      if (latency != 3) begin
        $display("Mismatch at %0t: ack_o latency got %0d expected 3", $time, latency);
        errors++;
      end
    end else if (hit_tgt == tbl_tgt[idx]) begin
      port = int'(tbl_tgt[idx]);
      check_addr("tgt_addr_o", seen_addr[port], tbl_addr[idx]);
      check_flag("tgt_write_o", seen_write[port], tbl_write[idx]);
      check_data("tgt_wdata_o", seen_wdata[port], tbl_wdata[idx]);
      check_tag("tgt_tag_o", seen_tag[port], tag_count[port]);
      tag_count[port] = tag_count[port] + 2'd1;
    end
    @(posedge clk);
    #1;
    req = 1'b0;
    do begin
      @(negedge clk);
    end while (ack !== 1'b0);
  endtask

  initial begin
    rst        = 1'b1;
    req        = 1'b0;
    write      = 1'b0;
    addr       = '0;
    wdata      = '0;
    id         = '0;
    resp_delay = '0;
    rng        = 32'h25df;
    errors     = 0;
    failed     = 0;
    for (int k = 0; k < `NOC_NUM_TGT; k++) begin
      tag_count[k] = '0;
    end
    load_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      err_before = errors;
      run_entry(i);
      if (errors == err_before) begin
        $display("Test %0d addr %h: passed", i, tbl_addr[i]);
      end else begin
        failed++;
        $display("Test %0d addr %h: failed", i, tbl_addr[i]);
      end
    end
    $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
             NUM_TESTS, NUM_TESTS - failed, failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+hdl
hdl/pe_noc_pkg.sv
hdl/pe_noc_addr_decoder.sv
hdl/pe_noc_txn_tagger.sv
hdl/pe_noc_port_ctrl.sv
hdl/pe_noc_top.sv
verification/pe_noc_properties.sv
verification/pe_noc_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the NoC testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module pe_noc_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vpe_noc_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
  exit 0
else
  exit 1
fi
